// ==== src/cacheGeomPkg.sv ====
package cacheGeomPkg;

  // byte address seen by the load/store unit
  localparam int AddrBits = 32;

  // processor word
  localparam int WordBits = 64;

  // 32-byte lines
  localparam int OffsetBits = 5;

  // four words per line
  localparam int WordSelBits = 2;

  typedef logic [AddrBits-1:0] addrT;
  typedef logic [WordBits-1:0] wordT;
  typedef logic [WordBits/8-1:0] byteMaskT;

  // byte address with the line offset removed
  typedef logic [AddrBits-OffsetBits-1:0] lineAddrT;
  typedef logic [(WordBits << WordSelBits)-1:0] lineT;

  // full line address kept per entry, so the set count stays out of this type
  typedef struct packed {
    lineAddrT lineAddr;
    logic     valid;
    logic     dirty;
  } metaT;

endpackage

// ==== src/memBusPkg.sv ====
package memBusPkg;

  // a line moves as a burst of 64-bit beats
  // refill: one address handshake, then beats with a last flag
  // write-back: the whole line in one handshake
  localparam int BeatsPerLine = 4;

  // position of a beat inside its burst
  typedef logic [$clog2(BeatsPerLine)-1:0] beatCntT;

endpackage

// ==== src/cacheArray.sv ====
`timescale 1ns/100ps

module cacheArray #(
  parameter int  Depth    = 64,
  parameter type payloadT = logic
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic [$clog2(Depth)-1:0] rdIndex_i,
  input  logic                     wrEn_i,
  input  logic [$clog2(Depth)-1:0] wrIndex_i,
  input  payloadT                  wrPayload_i,
  output payloadT                  rdPayload_o
);

  payloadT entries [Depth];

  // every entry starts invalid and clean
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < Depth; i++) begin
        entries[i] <= '0;
      end
    end else if (wrEn_i) begin
      entries[wrIndex_i] <= wrPayload_i;
    end
  end

  // read is combinational, a write shows on the next cycle
  assign rdPayload_o = entries[rdIndex_i];

endmodule

// ==== src/cpuReqPort.sv ====
`timescale 1ns/100ps

module cpuReqPort (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   req_i,
  input  logic                   we_i,
  input  cacheGeomPkg::addrT     addr_i,
  input  cacheGeomPkg::wordT     wrData_i,
  input  cacheGeomPkg::byteMaskT wrMask_i,
  input  logic                   reqDone_i,
  input  cacheGeomPkg::wordT     doneData_i,
  output logic                   ack_o,
  output cacheGeomPkg::wordT     rdData_o,
  output logic                   reqValid_o,
  output logic                   reqWe_o,
  output cacheGeomPkg::addrT     reqAddr_o,
  output cacheGeomPkg::wordT     reqData_o,
  output cacheGeomPkg::byteMaskT reqMask_o
);

  typedef enum logic [1:0] {
    waitReq,
    busy,
    waitDrop
  } stateT;

  stateT state;

  // four-phase handshake with the processor
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= waitReq;
    end else begin
      case (state)
        waitReq: begin
          if (req_i) begin
            state <= busy;
          end
        end
        busy: begin
          if (reqDone_i) begin
            state <= waitDrop;
          end
        end
        waitDrop: begin
          // ack stays up as long as req is held
          if (!req_i) begin
            state <= waitReq;
          end
        end
        default: begin
          state <= waitReq;
        end
      endcase
    end
  end

  // one extra cycle between capture and the cache seeing the request
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      reqValid_o <= 1'b0;
    end else begin
      reqValid_o <= (state == busy) && !reqDone_i;
    end
  end

  // request fields, stable for the whole access
  always_ff @(posedge clk) begin
    if (state == waitReq && req_i) begin
      reqWe_o   <= we_i;
      reqAddr_o <= addr_i;
      reqData_o <= wrData_i;
      reqMask_o <= wrMask_i;
    end
  end

  // returned word, merged word on stores
  always_ff @(posedge clk) begin
    if (reqDone_i) begin
      rdData_o <= doneData_i;
    end
  end

  assign ack_o = (state == waitDrop);

  ackNeedsReq: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(ack_o) |-> $past(req_i));

endmodule

// ==== src/cacheCtrl.sv ====
`timescale 1ns/100ps

module cacheCtrl #(
  parameter int IndexBits = 6
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   reqValid_i,
  input  logic                   reqWe_i,
  input  cacheGeomPkg::addrT     reqAddr_i,
  input  cacheGeomPkg::wordT     reqData_i,
  input  cacheGeomPkg::byteMaskT reqMask_i,
  input  cacheGeomPkg::metaT     meta0_i,
  input  cacheGeomPkg::metaT     meta1_i,
  input  cacheGeomPkg::lineT     line0_i,
  input  cacheGeomPkg::lineT     line1_i,
  input  logic                   fillDone_i,
  input  cacheGeomPkg::lineT     fillLine_i,
  input  logic                   wbDone_i,
  output logic                   reqDone_o,
  output cacheGeomPkg::wordT     doneData_o,
  output logic [IndexBits-1:0]   rdIndex_o,
  output logic                   metaWr0_o,
  output logic                   metaWr1_o,
  output logic                   dataWr0_o,
  output logic                   dataWr1_o,
  output logic [IndexBits-1:0]   wrIndex_o,
  output cacheGeomPkg::metaT     metaPayload_o,
  output cacheGeomPkg::lineT     linePayload_o,
  output logic                   fillStart_o,
  output cacheGeomPkg::lineAddrT fillAddr_o,
  output logic                   wbStart_o,
  output cacheGeomPkg::lineAddrT wbAddr_o,
  output cacheGeomPkg::lineT     wbLine_o
);

  typedef enum logic [2:0] {
    idle,
    lookup,
    wbWait,
    fillWait,
    install
  } stateT;

  stateT                                state;
  logic [IndexBits-1:0]                 index;
  cacheGeomPkg::lineAddrT               reqLine;
  logic [cacheGeomPkg::WordSelBits-1:0] wordSel;
  logic                                 hit0;
  logic                                 hit1;
  logic                                 anyHit;
  logic                                 storeHit;
  logic [2**IndexBits-1:0]              replPtr;
  logic                                 victimWay;
  cacheGeomPkg::metaT                   victMeta;
  logic                                 needWb;
  logic                                 miss;
  logic                                 wrWay0;
  logic                                 wrWay1;
  cacheGeomPkg::lineT                   selLine;
  cacheGeomPkg::lineT                   mergedLine;
  cacheGeomPkg::wordT                   curWord;
  cacheGeomPkg::wordT                   mergedWord;

  assign index   = reqAddr_i[cacheGeomPkg::OffsetBits +: IndexBits];
  assign reqLine = reqAddr_i[cacheGeomPkg::AddrBits-1:cacheGeomPkg::OffsetBits];
  assign wordSel = reqAddr_i[cacheGeomPkg::OffsetBits-1 -: cacheGeomPkg::WordSelBits];

  // tag compare against the full line address
  assign hit0   = meta0_i.valid && (meta0_i.lineAddr == reqLine);
  assign hit1   = meta1_i.valid && (meta1_i.lineAddr == reqLine);
  assign anyHit = hit0 || hit1;
  assign miss   = (state == lookup) && !anyHit;

  // victim comes from this set's toggle pointer
  assign victMeta = replPtr[index] ? meta1_i : meta0_i;
  assign needWb   = victMeta.valid && victMeta.dirty;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= idle;
      victimWay <= 1'b0;
      replPtr   <= '0;
    end else begin
      case (state)
        idle: begin
          if (reqValid_i) begin
            state <= lookup;
          end
        end
        lookup: begin
          if (anyHit) begin
            state <= idle;
          end else begin
            victimWay      <= replPtr[index];
            replPtr[index] <= !replPtr[index];
            state          <= needWb ? wbWait : fillWait;
          end
        end
        wbWait: begin
          if (wbDone_i) begin
            state <= fillWait;
          end
        end
        fillWait: begin
          if (fillDone_i) begin
            state <= install;
          end
        end
        install: begin
          // second lookup now hits the new line
          state <= lookup;
        end
        default: begin
          state <= idle;
        end
      endcase
    end
  end

  // word select and byte merge
  always_comb begin
    selLine = hit1 ? line1_i : line0_i;
    curWord = selLine[wordSel * cacheGeomPkg::WordBits +: cacheGeomPkg::WordBits];
    for (int b = 0; b < cacheGeomPkg::WordBits / 8; b++) begin
      mergedWord[b*8 +: 8] = reqMask_i[b] ? reqData_i[b*8 +: 8] : curWord[b*8 +: 8];
    end
    mergedLine = selLine;
    mergedLine[wordSel * cacheGeomPkg::WordBits +: cacheGeomPkg::WordBits] = mergedWord;
  end

  assign reqDone_o  = (state == lookup) && anyHit;
  assign doneData_o = reqWe_i ? mergedWord : curWord;

  // store hit marks the line dirty, install writes it clean
  assign storeHit = reqDone_o && reqWe_i;
  assign wrWay0   = (storeHit && hit0) || ((state == install) && !victimWay);
  assign wrWay1   = (storeHit && hit1) || ((state == install) && victimWay);

  assign rdIndex_o = index;
  assign wrIndex_o = index;
  assign metaWr0_o = wrWay0;
  assign metaWr1_o = wrWay1;
  assign dataWr0_o = wrWay0;
  assign dataWr1_o = wrWay1;

  assign metaPayload_o.lineAddr = reqLine;
  assign metaPayload_o.valid    = 1'b1;
  assign metaPayload_o.dirty    = (state != install);
  assign linePayload_o          = (state == install) ? fillLine_i : mergedLine;

  // refill either right away or once the dirty victim has left
  assign wbStart_o   = miss && needWb;
  assign wbAddr_o    = victMeta.lineAddr;
  assign wbLine_o    = replPtr[index] ? line1_i : line0_i;
  assign fillStart_o = (miss && !needWb) || ((state == wbWait) && wbDone_i);
  assign fillAddr_o  = reqLine;

  noDoubleHit: assert property (@(posedge clk) disable iff (!rst_n)
    (state == lookup) |-> !(hit0 && hit1));

endmodule

// ==== src/memPort.sv ====
`timescale 1ns/100ps

module memPort #(
  parameter int IndexBits = 6
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   fillStart_i,
  input  cacheGeomPkg::lineAddrT fillAddr_i,
  input  logic                   wbStart_i,
  input  cacheGeomPkg::lineAddrT wbAddr_i,
  input  cacheGeomPkg::lineT     wbLine_i,
  input  logic                   rdReady_i,
  input  logic                   rdDataValid_i,
  input  cacheGeomPkg::wordT     rdData_i,
  input  logic                   rdLast_i,
  input  logic                   wrReady_i,
  output logic                   fillDone_o,
  output cacheGeomPkg::lineT     fillLine_o,
  output logic                   wbDone_o,
  output logic                   rdValid_o,
  output cacheGeomPkg::addrT     rdAddr_o,
  output logic                   wrValid_o,
  output cacheGeomPkg::addrT     wrAddr_o,
  output cacheGeomPkg::lineT     wrLine_o
);

  logic               receiving;
  memBusPkg::beatCntT beatCnt;

  // read request held until accepted, then beats counted up to last
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rdValid_o  <= 1'b0;
      receiving  <= 1'b0;
      beatCnt    <= '0;
      fillDone_o <= 1'b0;
    end else begin
      fillDone_o <= 1'b0;
      if (fillStart_i) begin
        rdValid_o <= 1'b1;
      end else if (rdValid_o && rdReady_i) begin
        rdValid_o <= 1'b0;
        receiving <= 1'b1;
        beatCnt   <= '0;
      end
      if (receiving && rdDataValid_i) begin
        beatCnt <= beatCnt + memBusPkg::beatCntT'(1);
        if (rdLast_i) begin
          receiving  <= 1'b0;
          fillDone_o <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fillStart_i) begin
      rdAddr_o <= {fillAddr_i, {cacheGeomPkg::OffsetBits{1'b0}}};
    end
    // beat n lands in word n of the line
    if (receiving && rdDataValid_i) begin
      fillLine_o[beatCnt * cacheGeomPkg::WordBits +: cacheGeomPkg::WordBits] <= rdData_i;
    end
  end

  // write-back line handed over in one handshake
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wrValid_o <= 1'b0;
      wbDone_o  <= 1'b0;
    end else begin
      wbDone_o <= wrValid_o && wrReady_i;
      if (wbStart_i) begin
        wrValid_o <= 1'b1;
      end else if (wrValid_o && wrReady_i) begin
        wrValid_o <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wbStart_i) begin
      wrAddr_o <= {wbAddr_i, {cacheGeomPkg::OffsetBits{1'b0}}};
      wrLine_o <= wbLine_i;
    end
  end

  lastOnFinalBeat: assert property (@(posedge clk) disable iff (!rst_n)
    rdLast_i |-> receiving && rdDataValid_i
      && (beatCnt == memBusPkg::beatCntT'(memBusPkg::BeatsPerLine - 1)));

endmodule

// ==== src/dcacheTop.sv ====
`timescale 1ns/100ps

module dcacheTop #(
  parameter int IndexBits = 6
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   req_i,
  input  logic                   we_i,
  input  cacheGeomPkg::addrT     addr_i,
  input  cacheGeomPkg::wordT     wrData_i,
  input  cacheGeomPkg::byteMaskT wrMask_i,
  output logic                   ack_o,
  output cacheGeomPkg::wordT     rdData_o,
  output logic                   rdValid_o,
  input  logic                   rdReady_i,
  output cacheGeomPkg::addrT     rdAddr_o,
  input  logic                   rdDataValid_i,
  input  cacheGeomPkg::wordT     rdData_i,
  input  logic                   rdLast_i,
  output logic                   wrValid_o,
  input  logic                   wrReady_i,
  output cacheGeomPkg::addrT     wrAddr_o,
  output cacheGeomPkg::lineT     wrLine_o
);

  logic                   reqValid;
  logic                   reqWe;
  cacheGeomPkg::addrT     reqAddr;
  cacheGeomPkg::wordT     reqData;
  cacheGeomPkg::byteMaskT reqMask;
  logic                   reqDone;
  cacheGeomPkg::wordT     doneData;
  logic [IndexBits-1:0]   rdIndex;
  logic [IndexBits-1:0]   wrIndex;
  logic                   metaWr0;
  logic                   metaWr1;
  logic                   dataWr0;
  logic                   dataWr1;
  cacheGeomPkg::metaT     metaPayload;
  cacheGeomPkg::lineT     linePayload;
  cacheGeomPkg::metaT     meta0;
  cacheGeomPkg::metaT     meta1;
  cacheGeomPkg::lineT     line0;
  cacheGeomPkg::lineT     line1;
  logic                   fillStart;
  cacheGeomPkg::lineAddrT fillAddr;
  logic                   fillDone;
  cacheGeomPkg::lineT     fillLine;
  logic                   wbStart;
  cacheGeomPkg::lineAddrT wbAddr;
  cacheGeomPkg::lineT     wbLine;
  logic                   wbDone;

  cpuReqPort i_cpuReqPort (
    .clk        (clk),
    .rst_n      (rst_n),
    .req_i      (req_i),
    .we_i       (we_i),
    .addr_i     (addr_i),
    .wrData_i   (wrData_i),
    .wrMask_i   (wrMask_i),
    .reqDone_i  (reqDone),
    .doneData_i (doneData),
    .ack_o      (ack_o),
    .rdData_o   (rdData_o),
    .reqValid_o (reqValid),
    .reqWe_o    (reqWe),
    .reqAddr_o  (reqAddr),
    .reqData_o  (reqData),
    .reqMask_o  (reqMask)
  );

  cacheCtrl #(
    .IndexBits (IndexBits)
  ) i_cacheCtrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .reqValid_i    (reqValid),
    .reqWe_i       (reqWe),
    .reqAddr_i     (reqAddr),
    .reqData_i     (reqData),
    .reqMask_i     (reqMask),
    .meta0_i       (meta0),
    .meta1_i       (meta1),
    .line0_i       (line0),
    .line1_i       (line1),
    .fillDone_i    (fillDone),
    .fillLine_i    (fillLine),
    .wbDone_i      (wbDone),
    .reqDone_o     (reqDone),
    .doneData_o    (doneData),
    .rdIndex_o     (rdIndex),
    .metaWr0_o     (metaWr0),
    .metaWr1_o     (metaWr1),
    .dataWr0_o     (dataWr0),
    .dataWr1_o     (dataWr1),
    .wrIndex_o     (wrIndex),
    .metaPayload_o (metaPayload),
    .linePayload_o (linePayload),
    .fillStart_o   (fillStart),
    .fillAddr_o    (fillAddr),
    .wbStart_o     (wbStart),
    .wbAddr_o      (wbAddr),
    .wbLine_o      (wbLine)
  );

  // metadata and line storage, one array per way
  cacheArray #(
    .Depth    (2**IndexBits),
    .payloadT (cacheGeomPkg::metaT)
  ) i_metaWay0 (
    .clk         (clk),
    .rst_n       (rst_n),
    .rdIndex_i   (rdIndex),
    .wrEn_i      (metaWr0),
    .wrIndex_i   (wrIndex),
    .wrPayload_i (metaPayload),
    .rdPayload_o (meta0)
  );

  cacheArray #(
    .Depth    (2**IndexBits),
    .payloadT (cacheGeomPkg::metaT)
  ) i_metaWay1 (
    .clk         (clk),
    .rst_n       (rst_n),
    .rdIndex_i   (rdIndex),
    .wrEn_i      (metaWr1),
    .wrIndex_i   (wrIndex),
    .wrPayload_i (metaPayload),
    .rdPayload_o (meta1)
  );

  cacheArray #(
    .Depth    (2**IndexBits),
    .payloadT (cacheGeomPkg::lineT)
  ) i_dataWay0 (
    .clk         (clk),
    .rst_n       (rst_n),
    .rdIndex_i   (rdIndex),
    .wrEn_i      (dataWr0),
    .wrIndex_i   (wrIndex),
    .wrPayload_i (linePayload),
    .rdPayload_o (line0)
  );

  cacheArray #(
    .Depth    (2**IndexBits),
    .payloadT (cacheGeomPkg::lineT)
  ) i_dataWay1 (
    .clk         (clk),
    .rst_n       (rst_n),
    .rdIndex_i   (rdIndex),
    .wrEn_i      (dataWr1),
    .wrIndex_i   (wrIndex),
    .wrPayload_i (linePayload),
    .rdPayload_o (line1)
  );

  memPort #(
    .IndexBits (IndexBits)
  ) i_memPort (
    .clk           (clk),
    .rst_n         (rst_n),
    .fillStart_i   (fillStart),
    .fillAddr_i    (fillAddr),
    .wbStart_i     (wbStart),
    .wbAddr_i      (wbAddr),
    .wbLine_i      (wbLine),
    .rdReady_i     (rdReady_i),
    .rdDataValid_i (rdDataValid_i),
    .rdData_i      (rdData_i),
    .rdLast_i      (rdLast_i),
    .wrReady_i     (wrReady_i),
    .fillDone_o    (fillDone),
    .fillLine_o    (fillLine),
    .wbDone_o      (wbDone),
    .rdValid_o     (rdValid_o),
    .rdAddr_o      (rdAddr_o),
    .wrValid_o     (wrValid_o),
    .wrAddr_o      (wrAddr_o),
    .wrLine_o      (wrLine_o)
  );

endmodule

// ==== bench/dcacheTb.sv ====
`timescale 1ns/100ps

module dcacheTb;

  localparam int IndexBits   = 6;
  localparam int Sets        = 2**IndexBits;
  localparam int TagBits     = cacheGeomPkg::AddrBits - cacheGeomPkg::OffsetBits - IndexBits;
  localparam int ClkPeriod   = 8;
  localparam int ResetCycles = 10;
  localparam int NumOps      = 400;
  // dirty eviction plus refill with both channels stalled, with margin
  localparam int OpBound     = 64;
  localparam int WatchdogNs  = (ResetCycles + NumOps * OpBound) * ClkPeriod;

  logic                   clk;
  logic                   rst_n;
  logic                   req_i;
  logic                   we_i;
  cacheGeomPkg::addrT     addr_i;
  cacheGeomPkg::wordT     wrData_i;
  cacheGeomPkg::byteMaskT wrMask_i;
  logic                   ack_o;
  cacheGeomPkg::wordT     rdData_o;
  logic                   rdValid_o;
  logic                   rdReady_i;
  cacheGeomPkg::addrT     rdAddr_o;
  logic                   rdDataValid_i;
  cacheGeomPkg::wordT     rdData_i;
  logic                   rdLast_i;
  logic                   wrValid_o;
  logic                   wrReady_i;
  cacheGeomPkg::addrT     wrAddr_o;
  cacheGeomPkg::lineT     wrLine_o;

  logic [31:0] lfsr;
  int          checks;
  int          errors;
  int          handshakeErrors;
  int          rdStall;
  int          wrStall;

  // sparse backing store and what the memory side saw
  cacheGeomPkg::lineT     memLines [cacheGeomPkg::lineAddrT];
  cacheGeomPkg::addrT     wbAddrQ [$];
  cacheGeomPkg::lineT     wbLineQ [$];
  cacheGeomPkg::addrT     fillQ [$];

  // reference model: flat word memory plus per-set way state
  cacheGeomPkg::wordT     modelMem [cacheGeomPkg::addrT];
  cacheGeomPkg::lineAddrT mTag [2][Sets];
  logic                   mValid [2][Sets];
  logic                   mDirty [2][Sets];
  logic                   mPtr [Sets];

  dcacheTop #(
    .IndexBits (IndexBits)
  ) i_dut (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_i         (req_i),
    .we_i          (we_i),
    .addr_i        (addr_i),
    .wrData_i      (wrData_i),
    .wrMask_i      (wrMask_i),
    .ack_o         (ack_o),
    .rdData_o      (rdData_o),
    .rdValid_o     (rdValid_o),
    .rdReady_i     (rdReady_i),
    .rdAddr_o      (rdAddr_o),
    .rdDataValid_i (rdDataValid_i),
    .rdData_i      (rdData_i),
    .rdLast_i      (rdLast_i),
    .wrValid_o     (wrValid_o),
    .wrReady_i     (wrReady_i),
    .wrAddr_o      (wrAddr_o),
    .wrLine_o      (wrLine_o)
  );

  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [63:0] randBits(input int n);
    logic [63:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsrNext(lfsr);
      r = {r[62:0], lfsr[0]};
    end
    return r;
  endfunction

  // contents of memory that was never written
  function automatic cacheGeomPkg::wordT patternWord(input cacheGeomPkg::addrT a);
    return {a ^ 32'h5ac3_19e7, ~a};
  endfunction

  function automatic cacheGeomPkg::wordT memWord(input cacheGeomPkg::lineAddrT la,
                                                 input memBusPkg::beatCntT beat);
    cacheGeomPkg::lineT line;
    cacheGeomPkg::wordT w;
    if (memLines.exists(la)) begin
      line = memLines[la];
      w = line[int'(beat) * 64 +: 64];
    end else begin
      w = patternWord({la, beat, 3'b000});
    end
    return w;
  endfunction

  function automatic cacheGeomPkg::wordT modelWord(input cacheGeomPkg::addrT a);
    cacheGeomPkg::wordT w;
    if (modelMem.exists(a)) begin
      w = modelMem[a];
    end else begin
      w = patternWord(a);
    end
    return w;
  endfunction

  function automatic cacheGeomPkg::lineT modelLine(input cacheGeomPkg::lineAddrT la);
    cacheGeomPkg::lineT r;
    for (int w = 0; w < memBusPkg::BeatsPerLine; w++) begin
      r[w * 64 +: 64] = modelWord({la, 2'(w), 3'b000});
    end
    return r;
  endfunction

  function automatic cacheGeomPkg::wordT mergeBytes(input cacheGeomPkg::wordT old,
                                                    input cacheGeomPkg::wordT data,
                                                    input cacheGeomPkg::byteMaskT mask);
    cacheGeomPkg::wordT r;
    r = old;
    for (int b = 0; b < 8; b++) begin
      if (mask[b]) begin
        r[b * 8 +: 8] = data[b * 8 +: 8];
      end
    end
    return r;
  endfunction

  task automatic checkValue(input string name, input logic [255:0] got,
                            input logic [255:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t ns %s: got %0h, expected %0h", $time, name, got, exp);
    end
  endtask

  initial begin : clockGen
    clk = 1'b0;
    forever begin
      #(ClkPeriod / 2) clk = ~clk;
    end
  end

  // ack may only rise while req is held and only fall once req is gone
  initial begin : handshakeMonitor
    logic ackSeen;
    logic reqSeen;
    ackSeen = 1'b0;
    reqSeen = 1'b0;
    handshakeErrors = 0;
    forever begin
      @(negedge clk);
      if (rst_n) begin
        if (ack_o && !ackSeen && !reqSeen) begin
          handshakeErrors++;
          $display("ERROR: at %0t ns ack_o rose while req_i was low", $time);
        end
        if (!ack_o && ackSeen && reqSeen) begin
          handshakeErrors++;
          $display("ERROR: at %0t ns ack_o fell while req_i was still high", $time);
        end
      end
      ackSeen = ack_o;
      reqSeen = req_i;
    end
  end

  initial begin : memResponder
    cacheGeomPkg::lineAddrT rdLine;
    memBusPkg::beatCntT     beatIdx;
    logic                   sending;
    int                     rdWait;
    int                     wrWait;
    rdReady_i     = 1'b0;
    rdDataValid_i = 1'b0;
    rdData_i      = '0;
    rdLast_i      = 1'b0;
    wrReady_i     = 1'b0;
    rdLine        = '0;
    beatIdx       = '0;
    sending       = 1'b0;
    rdWait        = 0;
    wrWait        = 0;
    forever begin
      @(posedge clk);
      #1;
      if (rst_n) begin
        // write-back channel, ready for one cycle after the stall
        if (wrReady_i) begin
          wrReady_i = 1'b0;
        end else if (wrValid_o) begin
          if (wrWait < wrStall) begin
            wrWait++;
          end else begin
            wrWait    = 0;
            wrReady_i = 1'b1;
            wbAddrQ.push_back(wrAddr_o);
            wbLineQ.push_back(wrLine_o);
            memLines[wrAddr_o[cacheGeomPkg::AddrBits-1:cacheGeomPkg::OffsetBits]] = wrLine_o;
          end
        end
        // refill channel
        rdDataValid_i = 1'b0;
        rdLast_i      = 1'b0;
        if (rdReady_i) begin
          rdReady_i = 1'b0;
          sending   = 1'b1;
          beatIdx   = '0;
        end else if (rdValid_o && !sending) begin
          if (rdWait < rdStall) begin
            rdWait++;
          end else begin
            rdWait    = 0;
            rdReady_i = 1'b1;
            rdLine    = rdAddr_o[cacheGeomPkg::AddrBits-1:cacheGeomPkg::OffsetBits];
            fillQ.push_back(rdAddr_o);
          end
        end
        if (sending) begin
          rdDataValid_i = 1'b1;
          rdData_i      = memWord(rdLine, beatIdx);
          rdLast_i      = (beatIdx == memBusPkg::beatCntT'(memBusPkg::BeatsPerLine - 1));
          if (rdLast_i) begin
            sending = 1'b0;
          end
          beatIdx = beatIdx + memBusPkg::beatCntT'(1);
        end
      end
    end
  end

  initial begin : watchdog
    #(WatchdogNs);
    $display("ERROR: simulation did not finish within %0d ns", WatchdogNs);
    $display("checks: %0d, errors: %0d, handshake errors: %0d", checks, errors,
             handshakeErrors);
    $display("Test failures found");
    $finish;
  end

  initial begin : stimulus
    logic [63:0]            rnd;
    logic                   opWe;
    logic [1:0]             setSel;
    logic [1:0]             tagSel;
    logic [1:0]             wordSel;
    logic [IndexBits-1:0]   setIdx;
    logic [TagBits-1:0]     tag;
    cacheGeomPkg::addrT     addr;
    cacheGeomPkg::lineAddrT lineAddr;
    cacheGeomPkg::wordT     data;
    cacheGeomPkg::wordT     expWord;
    cacheGeomPkg::byteMaskT mask;
    cacheGeomPkg::addrT     expWbAddr;
    cacheGeomPkg::lineT     expWbLine;
    logic                   expHit;
    logic                   expWb;
    logic                   stopped;
    int                     way;
    int                     latency;
    int                     hold;
    int                     gap;
    int                     wbTaken;
    int                     fillTaken;
    lfsr      = 32'h27ea;
    checks    = 0;
    errors    = 0;
    rdStall   = 0;
    wrStall   = 0;
    rst_n     = 1'b0;
    req_i     = 1'b0;
    we_i      = 1'b0;
    addr_i    = '0;
    wrData_i  = '0;
    wrMask_i  = '0;
    stopped   = 1'b0;
    wbTaken   = 0;
    fillTaken = 0;
    for (int s = 0; s < Sets; s++) begin
      mPtr[s] = 1'b0;
      for (int w = 0; w < 2; w++) begin
        mTag[w][s]   = '0;
        mValid[w][s] = 1'b0;
        mDirty[w][s] = 1'b0;
      end
    end
    repeat (ResetCycles) @(posedge clk);
    #1;
    rst_n = 1'b1;
    checkValue("ack_o", 256'(ack_o), 256'(1'b0));
    checkValue("rdValid_o", 256'(rdValid_o), 256'(1'b0));
    checkValue("wrValid_o", 256'(wrValid_o), 256'(1'b0));

    for (int op = 0; op < NumOps && !stopped; op++) begin
      rnd = randBits(1);
      opWe = rnd[0];
      rnd = randBits(2);
      setSel = rnd[1:0];
      rnd = randBits(2);
      tagSel = rnd[1:0];
      rnd = randBits(2);
      wordSel = rnd[1:0];
      data = randBits(64);
      rnd = randBits(8);
      mask = rnd[7:0];
      rnd = randBits(3);
      rdStall = int'(rnd[2:0]);
      rnd = randBits(3);
      wrStall = int'(rnd[2:0]);
      rnd = randBits(2);
      hold = int'(rnd[1:0]);
      rnd = randBits(1);
      gap = int'(rnd[0]);
      // four sets, four lines each, so every set overflows its two ways
      case (setSel)
        2'd0: setIdx = IndexBits'(3);
        2'd1: setIdx = IndexBits'(17);
        2'd2: setIdx = IndexBits'(42);
        default: setIdx = IndexBits'(63);
      endcase
      case (tagSel)
        2'd0: tag = TagBits'(32'h13);
        2'd1: tag = TagBits'(32'h0a6e);
        2'd2: tag = TagBits'(32'h14c9);
        default: tag = TagBits'(32'h1f0f2);
      endcase
      addr     = {tag, setIdx, wordSel, 3'b000};
      lineAddr = addr[cacheGeomPkg::AddrBits-1:cacheGeomPkg::OffsetBits];

      // predict hit, victim and write-back
      way = -1;
      for (int w = 0; w < 2; w++) begin
        if (mValid[w][setIdx] && mTag[w][setIdx] == lineAddr) begin
          way = w;
        end
      end
      expHit = (way >= 0);
      expWb  = 1'b0;
      if (!expHit) begin
        way = int'(mPtr[setIdx]);
        if (mValid[way][setIdx] && mDirty[way][setIdx]) begin
          expWb     = 1'b1;
          expWbAddr = {mTag[way][setIdx], {cacheGeomPkg::OffsetBits{1'b0}}};
          expWbLine = modelLine(mTag[way][setIdx]);
        end
        mPtr[setIdx]   = !mPtr[setIdx];
        mTag[way][setIdx]   = lineAddr;
        mValid[way][setIdx] = 1'b1;
        mDirty[way][setIdx] = 1'b0;
      end
      if (opWe) begin
        expWord = mergeBytes(modelWord(addr), data, mask);
        modelMem[addr] = expWord;
        mDirty[way][setIdx] = 1'b1;
      end else begin
        expWord = modelWord(addr);
      end

      req_i    = 1'b1;
      we_i     = opWe;
      addr_i   = addr;
      wrData_i = data;
      wrMask_i = mask;
      // latency counted from the edge that first sees req
      @(posedge clk);
      #1;
      latency = 0;
      while (!ack_o && latency < OpBound) begin
        @(posedge clk);
        #1;
        latency++;
      end
      if (!ack_o) begin
        errors++;
        $display("ERROR: access %0d to %h got no ack_o within %0d cycles", op, addr, OpBound);
        stopped = 1'b1;
      end else begin
        checkValue("rdData_o", 256'(rdData_o), 256'(expWord));
        if (expHit) begin
          checkValue("hit latency", 256'(latency), 256'(3));
        end
        // ack stays up while req is held
        repeat (hold) begin
          @(posedge clk);
          #1;
          checkValue("ack_o", 256'(ack_o), 256'(1'b1));
        end
        req_i = 1'b0;
        @(posedge clk);
        #1;
        checkValue("ack_o", 256'(ack_o), 256'(1'b0));

        if (wbAddrQ.size() != wbTaken + (expWb ? 1 : 0)) begin
          errors++;
          $display("ERROR: access %0d to %h expected %0d write-backs, memory saw %0d",
                   op, addr, expWb ? 1 : 0, wbAddrQ.size() - wbTaken);
          wbTaken = wbAddrQ.size();
        end else if (expWb) begin
          checkValue("wrAddr_o", 256'(wbAddrQ[wbTaken]), 256'(expWbAddr));
          checkValue("wrLine_o", wbLineQ[wbTaken], expWbLine);
          wbTaken++;
        end
        if (fillQ.size() != fillTaken + (expHit ? 0 : 1)) begin
          errors++;
          $display("ERROR: access %0d to %h expected %0d refills, memory saw %0d",
                   op, addr, expHit ? 0 : 1, fillQ.size() - fillTaken);
          fillTaken = fillQ.size();
        end else if (!expHit) begin
          checkValue("rdAddr_o", 256'(fillQ[fillTaken]),
                     256'({lineAddr, {cacheGeomPkg::OffsetBits{1'b0}}}));
          fillTaken++;
        end
        repeat (gap) begin
          @(posedge clk);
          #1;
        end
      end
    end

    repeat (2) @(posedge clk);
    $display("checks: %0d, errors: %0d, handshake errors: %0d", checks, errors,
             handshakeErrors);
    if (errors == 0 && handshakeErrors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// ==== files.f ====
src/cacheGeomPkg.sv
src/memBusPkg.sv
src/cacheArray.sv
src/cpuReqPort.sv
src/cacheCtrl.sv
src/memPort.sv
src/dcacheTop.sv
bench/dcacheTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# builds the data cache testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 --top-module dcacheTb -f files.f -o simDcache
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/simDcache > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "All tests passed!" "$LOG"; then
  exit 0
else
  echo "pass message not found in $LOG"
  exit 1
fi
